// ==== list.f ====
verilog/frog_pkg.sv
verilog/video_timing.sv
verilog/frog_gen.sv
verilog/lane_gen.sv
verilog/pixel_mixer.sv
verilog/frog_display.sv
bench/frog_display_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the frog display testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module frog_display_tb -f list.f -o frog_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/frog_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi

// ==== bench/frog_display_tb.sv ====
`timescale 1ns/1ps

module frog_display_tb;

    logic             clk = 1'b0;
    logic             arst_n;
    frog_pkg::coord_t frog_x;
    frog_pkg::coord_t frog_y;
    frog_pkg::color_t color;
    logic             hsync;
    logic             vsync;
    logic             de;

    // frog positions with frame counts, then sample pixels per position
    int               ent_x[$];
    int               ent_y[$];
    int               ent_frames[$];
    int               smp_ent[$];
    int               smp_x[$];
    int               smp_y[$];
    frog_pkg::color_t smp_sprite[$];
    int               smp_hits[$];
    int               total_frames = 0;
    bit               table_ready = 1'b0;

    // raster tracker state
    int   px = 0;
    int   line_px = 0;
    int   lines = 0;
    int   hs_low = 0;
    int   vs_low = 0;
    int   frame_cnt = 0;
    int   idle_left = 0;
    bit   started = 1'b0;
    logic prev_de = 1'b0;
    logic prev_hs = 1'b1;
    logic prev_vs = 1'b1;

    frog_display uut (
        .clk    (clk),
        .arst_n (arst_n),
        .frog_x (frog_x),
        .frog_y (frog_y),
        .color  (color),
        .hsync  (hsync),
        .vsync  (vsync),
        .de     (de)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_color(input string name, input frog_pkg::color_t exp,
                               input frog_pkg::color_t act);
        if (act !== exp) begin
            fail_run($sformatf("error at %0t ns: %s expected %b got %b", $time, name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("error at %0t ns: %s expected %b got %b", $time, name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            fail_run($sformatf("error at %0t ns: %s expected %0d got %0d", $time, name, exp, act));
        end
    endtask

    task automatic add_entry(input int x, input int y, input int frames);
        ent_x.push_back(x);
        ent_y.push_back(y);
        ent_frames.push_back(frames);
        total_frames += frames;
    endtask

    // sprite colour is hand-derived and BLACK where the lane must show through
    task automatic add_sample(input int x, input int y, input frog_pkg::color_t sprite);
        smp_ent.push_back(ent_x.size() - 1);
        smp_x.push_back(x);
        smp_y.push_back(y);
        smp_sprite.push_back(sprite);
        smp_hits.push_back(0);
    endtask

    task automatic load_table();
        // frog parked in the corner
        add_entry(0, 0, 1);
        add_sample(100, 10, frog_pkg::BLACK);
        add_sample(200, 100, frog_pkg::BLACK);
        add_sample(32, 271, frog_pkg::BLACK);
        add_sample(48, 272, frog_pkg::BLACK);
        add_sample(639, 470, frog_pkg::BLACK);
        add_sample(11, 7, frog_pkg::PUPIL);
        // on the road over a centre stripe
        add_entry(300, 400, 2);
        add_sample(311, 407, frog_pkg::PUPIL);
        add_sample(321, 406, frog_pkg::EYE_WHITE);
        add_sample(315, 407, frog_pkg::DARK_GREEN);
        add_sample(315, 415, frog_pkg::LIGHT_GREEN);
        add_sample(306, 424, frog_pkg::LIGHT_GREEN);
        add_sample(300, 400, frog_pkg::BLACK);
        // in the water with the old spot cleared and the next one not yet drawn
        add_entry(100, 40, 1);
        add_sample(112, 49, frog_pkg::EYE_WHITE);
        add_sample(125, 56, frog_pkg::DARK_GREEN);
        add_sample(110, 62, frog_pkg::DARK_GREEN);
        add_sample(311, 407, frog_pkg::BLACK);
        add_sample(611, 455, frog_pkg::BLACK);
        // bottom right corner of the active area
        add_entry(600, 448, 1);
        add_sample(620, 455, frog_pkg::PUPIL);
        add_sample(606, 464, frog_pkg::DARK_GREEN);
        add_sample(631, 479, frog_pkg::BLACK);
        add_sample(112, 49, frog_pkg::BLACK);
        table_ready = 1'b1;
    endtask

    function automatic frog_pkg::color_t lane_ref(input int x, input int y);
        int lane;
        int lane_row;
        lane = y / int'(frog_pkg::LANE_HEIGHT);
        lane_row = y % int'(frog_pkg::LANE_HEIGHT);
        if (lane == 0 || lane == 7 || lane == 14) begin
            return frog_pkg::GRASS;
        end
        if (lane <= 6) begin
            return frog_pkg::WATER;
        end
        if ((lane_row == 15 || lane_row == 16) && (x / int'(frog_pkg::DASH_LEN)) % 2 == 0) begin
            return frog_pkg::STRIPE;
        end
        return frog_pkg::ROAD;
    endfunction

    function automatic frog_pkg::color_t expected_pixel(input int s);
        if (smp_sprite[s] != frog_pkg::BLACK) begin
            return smp_sprite[s];
        end
        return lane_ref(smp_x[s], smp_y[s]);
    endfunction

    function automatic int entry_of(input int frame);
        int e;
        int end_frame;
        e = 0;
        end_frame = ent_frames[0];
        while (e < ent_frames.size() - 1 && frame >= end_frame) begin
            e++;
            end_frame += ent_frames[e];
        end
        return e;
    endfunction

    initial begin
        int i;
        int last_frame;
        int half_px;
        load_table();
        frog_x <= frog_pkg::coord_t'(ent_x[0]);
        frog_y <= frog_pkg::coord_t'(ent_y[0]);
        arst_n <= 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        half_px = (int'(frog_pkg::V_ACTIVE) / 2) * int'(frog_pkg::H_ACTIVE);
        last_frame = 0;
        // next position goes in halfway down the last frame of each entry
        for (i = 0; i < ent_x.size() - 1; i++) begin
            last_frame += ent_frames[i];
            wait (frame_cnt == last_frame - 1 && px >= half_px);
            @(posedge clk);
            frog_x <= frog_pkg::coord_t'(ent_x[i + 1]);
            frog_y <= frog_pkg::coord_t'(ent_y[i + 1]);
        end
        wait (frame_cnt == total_frames);
        for (i = 0; i < smp_x.size(); i++) begin
            check_count($sformatf("hits of sample %0d", i), ent_frames[smp_ent[i]], smp_hits[i]);
        end
        $display("Simulation PASSED");
        $finish;
    end

    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = (total_frames + 2) * int'(frog_pkg::H_TOTAL) * int'(frog_pkg::V_TOTAL) * 4;
        #(limit_ns);
        fail_run("timeout: the frames of the table did not finish in time");
    end

    always @(negedge clk) begin
        int s;
        int x;
        int y;
        if (!arst_n || idle_left > 0) begin
            check_color("color", frog_pkg::BLACK, color);
            check_bit("hsync", 1'b1, hsync);
            check_bit("vsync", 1'b1, vsync);
            check_bit("de", 1'b0, de);
            idle_left = arst_n ? idle_left - 1 : frog_pkg::PIPE_DELAY;
        end else begin
            // pixel 0,0 right after the pipeline fills
            if (!started) begin
                check_bit("de", 1'b1, de);
                started = 1'b1;
            end
            if (de) begin
                x = px % int'(frog_pkg::H_ACTIVE);
                y = px / int'(frog_pkg::H_ACTIVE);
                for (s = 0; s < smp_x.size(); s++) begin
                    if (smp_ent[s] == entry_of(frame_cnt) && smp_x[s] == x && smp_y[s] == y) begin
                        check_color($sformatf("color (%0d,%0d)", x, y), expected_pixel(s), color);
                        smp_hits[s]++;
                    end
                end
                px++;
                line_px++;
            end else begin
                check_color("color", frog_pkg::BLACK, color);
                if (prev_de) begin
                    check_count("de pixels per line", int'(frog_pkg::H_ACTIVE), line_px);
                    line_px = 0;
                    lines++;
                end
            end
            if (!hsync || !vsync) begin
                check_bit("de", 1'b0, de);
            end
            if (!hsync) begin
                hs_low++;
            end else if (!prev_hs) begin
                check_count("hsync low cycles", int'(frog_pkg::H_SYNC), hs_low);
                hs_low = 0;
            end
            if (!vsync) begin
                if (prev_vs) begin
                    check_count("active lines per frame", int'(frog_pkg::V_ACTIVE), lines);
                    lines = 0;
                    px = 0;
                    frame_cnt++;
                end
                vs_low++;
            end else if (!prev_vs) begin
                check_count("vsync low cycles",
                            int'(frog_pkg::V_SYNC) * int'(frog_pkg::H_TOTAL), vs_low);
                vs_low = 0;
            end
            prev_de = de;
            prev_hs = hsync;
            prev_vs = vsync;
        end
    end

endmodule

// ==== verilog/frog_display.sv ====
`timescale 1ns/1ps

module frog_display (
    input  logic             clk,
    input  logic             arst_n,
    input  frog_pkg::coord_t frog_x,
    input  frog_pkg::coord_t frog_y,
    output frog_pkg::color_t color,
    output logic             hsync,
    output logic             vsync,
    output logic             de
);

    frog_pkg::coord_t col;
    frog_pkg::coord_t row;
    logic             hsync_raw;
    logic             vsync_raw;
    logic             de_raw;
    logic             frame_start;
    frog_pkg::color_t frog_color;
    frog_pkg::color_t lane_color;

    video_timing u_timing (
        .clk         (clk),
        .arst_n      (arst_n),
        .col         (col),
        .row         (row),
        .hsync_raw   (hsync_raw),
        .vsync_raw   (vsync_raw),
        .de_raw      (de_raw),
        .frame_start (frame_start)
    );

    // sprite and background run in parallel off the same counters
    frog_gen u_frog (
        .clk         (clk),
        .arst_n      (arst_n),
        .col         (col),
        .row         (row),
        .frame_start (frame_start),
        .frog_x      (frog_x),
        .frog_y      (frog_y),
        .frog_color  (frog_color)
    );

    lane_gen u_lane (
        .clk        (clk),
        .arst_n     (arst_n),
        .col        (col),
        .row        (row),
        .lane_color (lane_color)
    );

    pixel_mixer u_mixer (
        .clk        (clk),
        .arst_n     (arst_n),
        .frog_color (frog_color),
        .lane_color (lane_color),
        .hsync_raw  (hsync_raw),
        .vsync_raw  (vsync_raw),
        .de_raw     (de_raw),
        .color      (color),
        .hsync      (hsync),
        .vsync      (vsync),
        .de         (de)
    );

endmodule

// ==== verilog/pixel_mixer.sv ====
`timescale 1ns/1ps

module pixel_mixer (
    input  logic             clk,
    input  logic             arst_n,
    input  frog_pkg::color_t frog_color,
    input  frog_pkg::color_t lane_color,
    input  logic             hsync_raw,
    input  logic             vsync_raw,
    input  logic             de_raw,
    output frog_pkg::color_t color,
    output logic             hsync,
    output logic             vsync,
    output logic             de
);

    logic             hsync_d1;
    logic             vsync_d1;
    logic             de_d1;
    frog_pkg::color_t mixed;

    // first stage lines up with the registered generator colours
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hsync_d1 <= 1'b1;
            vsync_d1 <= 1'b1;
            de_d1    <= 1'b0;
        end else begin
            hsync_d1 <= hsync_raw;
            vsync_d1 <= vsync_raw;
            de_d1    <= de_raw;
        end
    end

    // frog wins unless transparent, nothing shows in blanking
    always_comb begin
        if (!de_d1) begin
            mixed = frog_pkg::BLACK;
        end else if (frog_color != frog_pkg::BLACK) begin
            mixed = frog_color;
        end else begin
            mixed = lane_color;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            color <= frog_pkg::BLACK;
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
        end else begin
            color <= mixed;
            hsync <= hsync_d1;
            vsync <= vsync_d1;
            de    <= de_d1;
        end
    end

endmodule

// ==== verilog/lane_gen.sv ====
`timescale 1ns/1ps

module lane_gen (
    input  logic             clk,
    input  logic             arst_n,
    input  frog_pkg::coord_t col,
    input  frog_pkg::coord_t row,
    output frog_pkg::color_t lane_color
);

    frog_pkg::coord_t lane_idx;
    frog_pkg::coord_t lane_row;
    frog_pkg::coord_t dash_idx;
    logic             is_grass;
    logic             is_water;
    logic             is_road;
    logic             centre_row;
    logic             dash_on;
    frog_pkg::color_t bg;

    assign lane_idx = row / frog_pkg::LANE_HEIGHT;
    assign lane_row = row % frog_pkg::LANE_HEIGHT;
    assign dash_idx = col / frog_pkg::DASH_LEN;

    // grass at the bottom, in the middle and at the top
    assign is_grass = (lane_idx == 10'd0) || (lane_idx == 10'd7) || (lane_idx == 10'd14);
    assign is_water = (lane_idx >= 10'd1) && (lane_idx <= 10'd6);
    assign is_road  = (lane_idx >= 10'd8) && (lane_idx <= 10'd13);

    // rows 15 and 16 of a 32-row lane
    assign centre_row = (lane_row == (frog_pkg::LANE_HEIGHT >> 1) - 10'd1) ||
                        (lane_row == (frog_pkg::LANE_HEIGHT >> 1));

    // even dash segments are painted
    assign dash_on = !dash_idx[0];

    always_comb begin
        bg = frog_pkg::BLACK;
        if (is_grass) begin
            bg = frog_pkg::GRASS;
        end else if (is_water) begin
            bg = frog_pkg::WATER;
        end else if (is_road) begin
            if (centre_row && dash_on) begin
                bg = frog_pkg::STRIPE;
            end else begin
                bg = frog_pkg::ROAD;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lane_color <= frog_pkg::BLACK;
        end else begin
            lane_color <= bg;
        end
    end

endmodule

// ==== verilog/frog_gen.sv ====
`timescale 1ns/1ps

module frog_gen (
    input  logic             clk,
    input  logic             arst_n,
    input  frog_pkg::coord_t col,
    input  frog_pkg::coord_t row,
    input  logic             frame_start,
    input  frog_pkg::coord_t frog_x,
    input  frog_pkg::coord_t frog_y,
    output frog_pkg::color_t frog_color
);

    frog_pkg::coord_t pos_x;
    frog_pkg::coord_t pos_y;
    frog_pkg::coord_t lx;
    frog_pkg::coord_t ly;
    logic             in_frog;
    logic             is_pupil;
    logic             is_eye;
    logic             is_head;
    logic             is_body;
    logic             is_front_leg;
    logic             is_inner_leg;
    logic             is_outer_leg;
    frog_pkg::color_t sprite;

    // inclusive rectangle test on local sprite offsets
    function automatic logic in_box(
        input frog_pkg::coord_t x,
        input frog_pkg::coord_t y,
        input int               x0,
        input int               x1,
        input int               y0,
        input int               y1
    );
        return int'(x) >= x0 && int'(x) <= x1 && int'(y) >= y0 && int'(y) <= y1;
    endfunction

    // position only moves during vsync, so the sprite never tears
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pos_x <= '0;
            pos_y <= '0;
        end else if (frame_start) begin
            pos_x <= frog_x;
            pos_y <= frog_y;
        end
    end

    assign lx = col - pos_x;
    assign ly = row - pos_y;

    // offsets cannot wrap once col/row are at or past the corner
    assign in_frog = (col >= pos_x) && (row >= pos_y) &&
                     (lx < frog_pkg::FROG_SIZE) && (ly < frog_pkg::FROG_SIZE);

    always_comb begin
        is_pupil = in_box(lx, ly, 11, 12, 7, 8) ||
                   in_box(lx, ly, 19, 20, 7, 8);

        is_eye = in_box(lx, ly, 10, 13, 6, 8) ||
                 in_box(lx, ly, 11, 12, 9, 9) ||
                 in_box(lx, ly, 18, 21, 6, 8) ||
                 in_box(lx, ly, 19, 20, 9, 9);

        // head band plus the two side outlines
        is_head = in_box(lx, ly, 8, 23, 6, 10) ||
                  in_box(lx, ly, 8, 8, 10, 20) ||
                  in_box(lx, ly, 23, 23, 10, 20);

        is_body = in_box(lx, ly, 9, 22, 10, 20);

        is_front_leg = in_box(lx, ly, 7, 8, 13, 14) ||
                       in_box(lx, ly, 23, 24, 13, 14) ||
                       in_box(lx, ly, 6, 9, 15, 17) ||
                       in_box(lx, ly, 23, 25, 15, 17);

        is_inner_leg = in_box(lx, ly, 9, 11, 19, 23) ||
                       in_box(lx, ly, 20, 22, 19, 23);

        is_outer_leg = in_box(lx, ly, 6, 8, 21, 25) ||
                       in_box(lx, ly, 23, 25, 21, 25);
    end

    // highest priority first
    always_comb begin
        sprite = frog_pkg::BLACK;
        if (is_pupil) begin
            sprite = frog_pkg::PUPIL;
        end else if (is_eye) begin
            sprite = frog_pkg::EYE_WHITE;
        end else if (is_head) begin
            sprite = frog_pkg::DARK_GREEN;
        end else if (is_body) begin
            sprite = frog_pkg::LIGHT_GREEN;
        end else if (is_front_leg || is_inner_leg) begin
            sprite = frog_pkg::DARK_GREEN;
        end else if (is_outer_leg) begin
            sprite = frog_pkg::LIGHT_GREEN;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            frog_color <= frog_pkg::BLACK;
        end else begin
            frog_color <= in_frog ? sprite : frog_pkg::BLACK;
        end
    end

endmodule

// ==== verilog/video_timing.sv ====
`timescale 1ns/1ps

module video_timing (
    input  logic             clk,
    input  logic             arst_n,
    output frog_pkg::coord_t col,
    output frog_pkg::coord_t row,
    output logic             hsync_raw,
    output logic             vsync_raw,
    output logic             de_raw,
    output logic             frame_start
);

    frog_pkg::coord_t h_cnt;
    frog_pkg::coord_t v_cnt;
    frog_pkg::coord_t h_next;
    frog_pkg::coord_t v_next;
    logic             h_last;
    logic             v_last;
    logic             hsync_next;
    logic             vsync_next;
    logic             fstart_next;

    assign h_last = (h_cnt == frog_pkg::H_TOTAL - 10'd1);
    assign v_last = (v_cnt == frog_pkg::V_TOTAL - 10'd1);

    always_comb begin
        h_next = h_last ? 10'd0 : h_cnt + 10'd1;
        v_next = v_cnt;
        if (h_last) begin
            v_next = v_last ? 10'd0 : v_cnt + 10'd1;
        end
    end

    // syncs are formed from the next count so they stay aligned with col/row
    always_comb begin
        hsync_next = !(h_next >= frog_pkg::H_ACTIVE + frog_pkg::H_FRONT &&
                       h_next <  frog_pkg::H_ACTIVE + frog_pkg::H_FRONT + frog_pkg::H_SYNC);
        vsync_next = !(v_next >= frog_pkg::V_ACTIVE + frog_pkg::V_FRONT &&
                       v_next <  frog_pkg::V_ACTIVE + frog_pkg::V_FRONT + frog_pkg::V_SYNC);
        // first pixel clock of the vsync pulse
        fstart_next = (h_next == 10'd0) &&
                      (v_next == frog_pkg::V_ACTIVE + frog_pkg::V_FRONT);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt       <= '0;
            v_cnt       <= '0;
            hsync_raw   <= 1'b1;
            vsync_raw   <= 1'b1;
            frame_start <= 1'b0;
        end else begin
            h_cnt       <= h_next;
            v_cnt       <= v_next;
            hsync_raw   <= hsync_next;
            vsync_raw   <= vsync_next;
            frame_start <= fstart_next;
        end
    end

    assign de_raw = (h_cnt < frog_pkg::H_ACTIVE) && (v_cnt < frog_pkg::V_ACTIVE);

    assign col = h_cnt;
    assign row = v_cnt;

endmodule

// ==== verilog/frog_pkg.sv ====
package frog_pkg;

    // pixel coordinate, wide enough for the full 800x525 raster
    typedef logic [9:0] coord_t;

    // two bits each, rr_gg_bb
    typedef logic [5:0] color_t;

    // horizontal timing, in pixel clocks
    localparam coord_t H_ACTIVE = 10'd640;
    localparam coord_t H_FRONT  = 10'd16;
    localparam coord_t H_SYNC   = 10'd96;
    localparam coord_t H_BACK   = 10'd48;
    localparam coord_t H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    // vertical timing, in lines
    localparam coord_t V_ACTIVE = 10'd480;
    localparam coord_t V_FRONT  = 10'd10;
    localparam coord_t V_SYNC   = 10'd2;
    localparam coord_t V_BACK   = 10'd33;
    localparam coord_t V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // sprite is a square of this many pixels
    localparam coord_t FROG_SIZE = 10'd32;

    // 480 / 32 gives 15 lanes
    localparam coord_t LANE_HEIGHT = 10'd32;

    // half period of the road centre dash
    localparam coord_t DASH_LEN = 10'd16;

    // sprite colours
    localparam color_t LIGHT_GREEN = 6'b001100;
    localparam color_t DARK_GREEN  = 6'b000101;
    localparam color_t ORANGE      = 6'b110100;
    localparam color_t EYE_WHITE   = 6'b111111;
    localparam color_t PUPIL       = 6'b000001;

    // background colours
    localparam color_t GRASS  = 6'b001000;
    localparam color_t WATER  = 6'b000010;
    localparam color_t ROAD   = 6'b010101;
    localparam color_t STRIPE = 6'b111100;

    // also the transparent sprite value
    localparam color_t BLACK = 6'b000000;

    // counter position to output pixel, in clocks
    localparam int PIPE_DELAY = 2;

endpackage
